// File: filelist.f
rtl/tile_conf_pkg.sv
rtl/tile_inst_pkg.sv
rtl/dispatch_ctrl.sv
rtl/int_regfile.sv
rtl/alu_pipe.sv
rtl/bru_pipe.sv
rtl/rob.sv
rtl/tile_top.sv
tests/tb_tile_top.sv

// File: rtl/alu_pipe.sv
// Integer ALU pipe
`timescale 1ns/1ps

module alu_pipe
  import tile_conf_pkg::*;
  import tile_inst_pkg::*;
#(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  alu_op_e          i_op,
  input  data_t            i_a,
  input  data_t            i_b,
  input  reg_idx_t         i_rd,
  input  logic [TAG_W-1:0] i_tag,
  output logic             o_wb_valid,
  output reg_idx_t         o_wb_rd,
  output data_t            o_wb_data,
  output logic [TAG_W-1:0] o_wb_tag
);

  data_t w_result;
  logic  w_slt;

  assign w_slt = ($signed(i_a) < $signed(i_b));

  always_comb begin
    unique case (i_op)
      ADD: w_result = i_a + i_b;
      SUB: w_result = i_a - i_b;
      AND: w_result = i_a & i_b;
      OR:  w_result = i_a | i_b;
      XOR: w_result = i_a ^ i_b;
      SLL: w_result = i_a << i_b[4:0];
      SRL: w_result = i_a >> i_b[4:0];
      SLT: w_result = {{(DATA_W-1){1'b0}}, w_slt};
    endcase
  end

  // --------------------
  // Writeback stage
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_rd   <= i_rd;
    o_wb_data <= w_result;
    o_wb_tag  <= i_tag;
  end

endmodule : alu_pipe

// File: rtl/bru_pipe.sv
// Branch compare pipe
`timescale 1ns/1ps

module bru_pipe
  import tile_conf_pkg::*;
  import tile_inst_pkg::*;
#(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_valid,
  input  br_cond_e         i_cond,
  input  data_t            i_a,
  input  data_t            i_b,
  input  pc_t              i_target,
  input  logic [TAG_W-1:0] i_tag,
  output logic             o_done_valid,
  output logic [TAG_W-1:0] o_done_tag,
  output logic             o_taken,
  output pc_t              o_target
);

  logic             w_eq;
  logic             w_lt;
  logic             w_ltu;
  logic             w_taken;
  logic             r_s1_valid;
  logic             r_s1_taken;
  pc_t              r_s1_target;
  logic [TAG_W-1:0] r_s1_tag;

  assign w_eq  = (i_a == i_b);
  assign w_lt  = ($signed(i_a) < $signed(i_b));
  assign w_ltu = (i_a < i_b);

  always_comb begin
    w_taken = 1'b0;
    case (i_cond)
      EQ:     w_taken = w_eq;
      NE:     w_taken = ~w_eq;
      LT:     w_taken = w_lt;
      GE:     w_taken = ~w_lt;
      LTU:    w_taken = w_ltu;
      GEU:    w_taken = ~w_ltu;
      ALWAYS: w_taken = 1'b1;
      NEVER:  w_taken = 1'b0;
    endcase
  end

  // Stage 1 holds the decision, stage 2 reports
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_s1_valid   <= 1'b0;
      o_done_valid <= 1'b0;
    end else begin
      r_s1_valid   <= i_valid;
      o_done_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_taken  <= w_taken;
    r_s1_target <= i_target;
    r_s1_tag    <= i_tag;
    o_taken     <= r_s1_taken;
    o_target    <= r_s1_target;
    o_done_tag  <= r_s1_tag;
  end

endmodule : bru_pipe

// File: rtl/dispatch_ctrl.sv
// Dispatch and scoreboard
`timescale 1ns/1ps

module dispatch_ctrl
  import tile_conf_pkg::*;
  import tile_inst_pkg::*;
#(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_disp_valid,
  input  inst_word_u       i_disp_inst,
  input  pc_t              i_disp_pc,
  output logic             o_disp_ready,
  output reg_idx_t         o_rd_idx1,
  output reg_idx_t         o_rd_idx2,
  input  data_t            i_rd_data1,
  input  data_t            i_rd_data2,
  input  logic             i_wb_valid,
  input  reg_idx_t         i_wb_rd,
  input  logic             i_rob_full,
  input  logic [TAG_W-1:0] i_alloc_tag,
  output logic             o_alu_valid,
  output alu_op_e          o_alu_op,
  output data_t            o_alu_a,
  output data_t            o_alu_b,
  output reg_idx_t         o_alu_rd,
  output logic [TAG_W-1:0] o_alu_tag,
  output logic             o_bru_valid,
  output br_cond_e         o_bru_cond,
  output data_t            o_bru_a,
  output data_t            o_bru_b,
  output pc_t              o_bru_target,
  output logic [TAG_W-1:0] o_bru_tag,
  output logic             o_alloc_valid,
  output logic             o_alloc_illegal,
  output logic             o_alloc_is_br
);

  inst_cat_e          w_cat;
  logic               w_is_alu;
  logic               w_is_bru;
  logic               w_use_rs2;
  logic               w_hazard;
  logic               w_accept;
  data_t              w_imm;
  pc_t                w_target;
  logic [REG_NUM-1:0] r_pending;

  // --------------------
  // Decode
  // --------------------
  assign w_cat    = i_disp_inst.alu.cat;
  assign w_is_alu = (w_cat == CAT_ALU);
  assign w_is_bru = (w_cat == CAT_BRU);

  assign o_rd_idx1 = w_is_bru ? i_disp_inst.bru.rs1 : i_disp_inst.alu.rs1;
  assign o_rd_idx2 = w_is_bru ? i_disp_inst.bru.rs2 : i_disp_inst.alu.rs2;
  assign w_use_rs2 = w_is_bru | (w_is_alu & ~i_disp_inst.alu.imm_en);

  assign w_imm    = {{(DATA_W-14){i_disp_inst.alu.imm[13]}}, i_disp_inst.alu.imm};
  assign w_target = i_disp_pc + {{13{i_disp_inst.bru.offset[18]}}, i_disp_inst.bru.offset};

  // Illegal words read nothing
  assign w_hazard = ((w_is_alu | w_is_bru) & r_pending[o_rd_idx1]) |
                    (w_use_rs2 & r_pending[o_rd_idx2]);

  assign o_disp_ready = ~i_rob_full & ~w_hazard;
  assign w_accept     = i_disp_valid & o_disp_ready;

  // Every accepted word takes a ROB entry
  assign o_alloc_valid   = w_accept;
  assign o_alloc_illegal = ~(w_is_alu | w_is_bru);
  assign o_alloc_is_br   = w_is_bru;

  // Set wins over a same-edge clear
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_pending <= '0;
    end else begin
      if (i_wb_valid) begin
        r_pending[i_wb_rd] <= 1'b0;
      end
      if (w_accept && w_is_alu) begin
        r_pending[i_disp_inst.alu.rd] <= 1'b1;
      end
    end
  end

  // --------------------
  // Issue
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alu_valid <= 1'b0;
      o_bru_valid <= 1'b0;
    end else begin
      o_alu_valid <= w_accept & w_is_alu;
      o_bru_valid <= w_accept & w_is_bru;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_alu_op     <= i_disp_inst.alu.op;
      o_alu_a      <= i_rd_data1;
      o_alu_b      <= i_disp_inst.alu.imm_en ? w_imm : i_rd_data2;
      o_alu_rd     <= i_disp_inst.alu.rd;
      o_alu_tag    <= i_alloc_tag;
      o_bru_cond   <= i_disp_inst.bru.cond;
      o_bru_a      <= i_rd_data1;
      o_bru_b      <= i_rd_data2;
      o_bru_target <= w_target;
      o_bru_tag    <= i_alloc_tag;
    end
  end

endmodule : dispatch_ctrl

// File: rtl/int_regfile.sv
// Integer register file
`timescale 1ns/1ps

module int_regfile
  import tile_conf_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rd_idx1,
  input  reg_idx_t i_rd_idx2,
  input  logic     i_wr_valid,
  input  reg_idx_t i_wr_idx,
  input  data_t    i_wr_data,
  output data_t    o_rd_data1,
  output data_t    o_rd_data2
);

  data_t r_regs [REG_NUM];

  // Registers start at zero
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < REG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wr_valid) begin
      r_regs[i_wr_idx] <= i_wr_data;
    end
  end

  // No bypass, the scoreboard covers it
  assign o_rd_data1 = r_regs[i_rd_idx1];
  assign o_rd_data2 = r_regs[i_rd_idx2];

endmodule : int_regfile

// File: rtl/rob.sv
// Reorder buffer
`timescale 1ns/1ps

module rob
  import tile_conf_pkg::*;
#(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_alloc_valid,
  input  logic             i_alloc_illegal,
  input  logic             i_alloc_is_br,
  output logic [TAG_W-1:0] o_alloc_tag,
  output logic             o_full,
  input  logic             i_alu_done_valid,
  input  logic [TAG_W-1:0] i_alu_done_tag,
  input  reg_idx_t         i_alu_rd,
  input  data_t            i_alu_data,
  input  logic             i_bru_done_valid,
  input  logic [TAG_W-1:0] i_bru_done_tag,
  input  logic             i_bru_taken,
  input  pc_t              i_bru_target,
  output logic             o_cmt_valid,
  output logic             o_cmt_illegal,
  output logic             o_cmt_is_br,
  output reg_idx_t         o_cmt_rd,
  output data_t            o_cmt_data,
  output logic             o_cmt_br_taken,
  output pc_t              o_cmt_br_target
);

  logic [TAG_W-1:0]   r_head;
  logic [TAG_W-1:0]   r_tail;
  logic [TAG_W:0]     r_count;
  logic [ROB_DEPTH-1:0] r_done;

  logic     r_illegal [ROB_DEPTH];
  logic     r_is_br   [ROB_DEPTH];
  reg_idx_t r_rd      [ROB_DEPTH];
  data_t    r_data    [ROB_DEPTH];
  logic     r_taken   [ROB_DEPTH];
  pc_t      r_target  [ROB_DEPTH];

  assign o_alloc_tag = r_tail;
  assign o_full      = (r_count == (TAG_W+1)'(ROB_DEPTH));

  // --------------------
  // Pointers and status
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
      r_done  <= '0;
    end else begin
      if (i_alu_done_valid) begin
        r_done[i_alu_done_tag] <= 1'b1;
      end
      if (i_bru_done_valid) begin
        r_done[i_bru_done_tag] <= 1'b1;
      end
      // Illegal entries never see a pipe
      if (i_alloc_valid) begin
        r_done[r_tail] <= i_alloc_illegal;
        r_tail         <= r_tail + 1'b1;
      end
      if (o_cmt_valid) begin
        r_head <= r_head + 1'b1;
      end
      r_count <= r_count + i_alloc_valid - o_cmt_valid;
    end
  end

  // Entry payload
  always_ff @(posedge i_clk) begin
    if (i_alloc_valid) begin
      r_illegal[r_tail] <= i_alloc_illegal;
      r_is_br[r_tail]   <= i_alloc_is_br;
    end
    if (i_alu_done_valid) begin
      r_rd[i_alu_done_tag]   <= i_alu_rd;
      r_data[i_alu_done_tag] <= i_alu_data;
    end
    if (i_bru_done_valid) begin
      r_taken[i_bru_done_tag]  <= i_bru_taken;
      r_target[i_bru_done_tag] <= i_bru_target;
    end
  end

  // --------------------
  // Commit
  // --------------------
  assign o_cmt_valid     = (r_count != '0) & r_done[r_head];
  assign o_cmt_illegal   = r_illegal[r_head];
  assign o_cmt_is_br     = r_is_br[r_head];
  assign o_cmt_rd        = r_rd[r_head];
  assign o_cmt_data      = r_data[r_head];
  assign o_cmt_br_taken  = r_taken[r_head];
  assign o_cmt_br_target = r_target[r_head];

endmodule : rob

// File: rtl/tile_conf_pkg.sv
// Tile slice configuration

package tile_conf_pkg;

  // --------------------
  // Datapath
  // --------------------
  localparam int DATA_W = 32;

  // Register file size
  localparam int REG_NUM = 16;

  // --------------------
  // Common types
  // --------------------
  typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;

  typedef logic [DATA_W-1:0] data_t;

  // Fetch address of an instruction
  typedef logic [31:0] pc_t;

endpackage : tile_conf_pkg

// File: rtl/tile_inst_pkg.sv
// Instruction formats

package tile_inst_pkg;

  import tile_conf_pkg::*;

  // Top two bits of every word
  typedef enum logic [1:0] {
    CAT_ALU  = 2'd0,
    CAT_BRU  = 2'd1,
    CAT_RSV2 = 2'd2,
    CAT_RSV3 = 2'd3
  } inst_cat_e;

  // Shifts use b[4:0], SLT is signed
  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
  } alu_op_e;

  typedef enum logic [2:0] {
    EQ, NE, LT, GE, LTU, GEU, ALWAYS, NEVER
  } br_cond_e;

  // --------------------
  // Word layouts
  // --------------------
  typedef struct packed {
    inst_cat_e   cat;
    alu_op_e     op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        imm_en;
    logic [13:0] imm;
  } alu_inst_t;

  typedef struct packed {
    inst_cat_e   cat;
    br_cond_e    cond;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [18:0] offset;
  } bru_inst_t;

  // Category sits in the same bits of both views
  typedef union packed {
    alu_inst_t alu;
    bru_inst_t bru;
  } inst_word_u;

endpackage : tile_inst_pkg

// File: rtl/tile_top.sv
// Execution slice top
`timescale 1ns/1ps

module tile_top
  import tile_conf_pkg::*;
  import tile_inst_pkg::*;
#(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_disp_valid,
  input  inst_word_u i_disp_inst,
  input  pc_t        i_disp_pc,
  output logic       o_disp_ready,
  output logic       o_cmt_valid,
  output logic       o_cmt_illegal,
  output logic       o_cmt_is_br,
  output reg_idx_t   o_cmt_rd,
  output data_t      o_cmt_data,
  output logic       o_cmt_br_taken,
  output pc_t        o_cmt_br_target
);

  reg_idx_t         w_rd_idx1;
  reg_idx_t         w_rd_idx2;
  data_t            w_rd_data1;
  data_t            w_rd_data2;
  logic             w_rob_full;
  logic [TAG_W-1:0] w_alloc_tag;
  logic             w_alloc_valid;
  logic             w_alloc_illegal;
  logic             w_alloc_is_br;

  // --------------------
  // ALU issue and writeback
  // --------------------
  logic             w_alu_valid;
  alu_op_e          w_alu_op;
  data_t            w_alu_a;
  data_t            w_alu_b;
  reg_idx_t         w_alu_rd;
  logic [TAG_W-1:0] w_alu_tag;
  logic             w_wb_valid;
  reg_idx_t         w_wb_rd;
  data_t            w_wb_data;
  logic [TAG_W-1:0] w_wb_tag;

  // --------------------
  // Branch issue and report
  // --------------------
  logic             w_bru_valid;
  br_cond_e         w_bru_cond;
  data_t            w_bru_a;
  data_t            w_bru_b;
  pc_t              w_bru_target;
  logic [TAG_W-1:0] w_bru_tag;
  logic             w_br_done_valid;
  logic [TAG_W-1:0] w_br_done_tag;
  logic             w_br_taken;
  pc_t              w_br_target;

  dispatch_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch_ctrl (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_disp_valid(i_disp_valid), .i_disp_inst(i_disp_inst), .i_disp_pc(i_disp_pc),
    .o_disp_ready(o_disp_ready),
    .o_rd_idx1(w_rd_idx1), .o_rd_idx2(w_rd_idx2),
    .i_rd_data1(w_rd_data1), .i_rd_data2(w_rd_data2),
    .i_wb_valid(w_wb_valid), .i_wb_rd(w_wb_rd),
    .i_rob_full(w_rob_full), .i_alloc_tag(w_alloc_tag),
    .o_alu_valid(w_alu_valid), .o_alu_op(w_alu_op), .o_alu_a(w_alu_a),
    .o_alu_b(w_alu_b), .o_alu_rd(w_alu_rd), .o_alu_tag(w_alu_tag),
    .o_bru_valid(w_bru_valid), .o_bru_cond(w_bru_cond), .o_bru_a(w_bru_a),
    .o_bru_b(w_bru_b), .o_bru_target(w_bru_target), .o_bru_tag(w_bru_tag),
    .o_alloc_valid(w_alloc_valid), .o_alloc_illegal(w_alloc_illegal),
    .o_alloc_is_br(w_alloc_is_br)
  );

  int_regfile u_int_regfile (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_rd_idx1(w_rd_idx1), .i_rd_idx2(w_rd_idx2),
    .i_wr_valid(w_wb_valid), .i_wr_idx(w_wb_rd), .i_wr_data(w_wb_data),
    .o_rd_data1(w_rd_data1), .o_rd_data2(w_rd_data2)
  );

  alu_pipe #(.ROB_DEPTH(ROB_DEPTH)) u_alu_pipe (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(w_alu_valid), .i_op(w_alu_op), .i_a(w_alu_a), .i_b(w_alu_b),
    .i_rd(w_alu_rd), .i_tag(w_alu_tag),
    .o_wb_valid(w_wb_valid), .o_wb_rd(w_wb_rd), .o_wb_data(w_wb_data),
    .o_wb_tag(w_wb_tag)
  );

  bru_pipe #(.ROB_DEPTH(ROB_DEPTH)) u_bru_pipe (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(w_bru_valid), .i_cond(w_bru_cond), .i_a(w_bru_a), .i_b(w_bru_b),
    .i_target(w_bru_target), .i_tag(w_bru_tag),
    .o_done_valid(w_br_done_valid), .o_done_tag(w_br_done_tag),
    .o_taken(w_br_taken), .o_target(w_br_target)
  );

  rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_alloc_valid(w_alloc_valid), .i_alloc_illegal(w_alloc_illegal),
    .i_alloc_is_br(w_alloc_is_br), .o_alloc_tag(w_alloc_tag), .o_full(w_rob_full),
    .i_alu_done_valid(w_wb_valid), .i_alu_done_tag(w_wb_tag),
    .i_alu_rd(w_wb_rd), .i_alu_data(w_wb_data),
    .i_bru_done_valid(w_br_done_valid), .i_bru_done_tag(w_br_done_tag),
    .i_bru_taken(w_br_taken), .i_bru_target(w_br_target),
    .o_cmt_valid(o_cmt_valid), .o_cmt_illegal(o_cmt_illegal), .o_cmt_is_br(o_cmt_is_br),
    .o_cmt_rd(o_cmt_rd), .o_cmt_data(o_cmt_data),
    .o_cmt_br_taken(o_cmt_br_taken), .o_cmt_br_target(o_cmt_br_target)
  );

endmodule : tile_top

// File: tests/tb_tile_top.sv
// Tile slice testbench
`timescale 1ns/1ps

module tb_tile_top
  import tile_conf_pkg::*;
  import tile_inst_pkg::*;
;

  localparam int          ROB_DEPTH      = 8;
  localparam int          N_INSTR        = 400;
  localparam int          TIMEOUT_CYCLES = N_INSTR * 10 + 200;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
  localparam pc_t         PC_BASE        = 32'h0001_0000;

  typedef struct packed {
    logic     illegal;
    logic     is_br;
    reg_idx_t rd;
    data_t    data;
    logic     taken;
    pc_t      target;
  } cmt_exp_t;

  logic       clk;
  logic       rst_n;
  logic       disp_valid;
  inst_word_u disp_inst;
  pc_t        disp_pc;
  logic       disp_ready;
  logic       cmt_valid;
  logic       cmt_illegal;
  logic       cmt_is_br;
  reg_idx_t   cmt_rd;
  data_t      cmt_data;
  logic       cmt_br_taken;
  pc_t        cmt_br_target;

  logic [31:0] lfsr_state;
  data_t       model_regs [REG_NUM];
  cmt_exp_t    exp_q [$];
  int          n_accepted;
  int          n_committed;
  int          cycle_count;
  int          n_alu_cmt;
  int          n_br_cmt;
  int          n_ill_cmt;

  tile_top #(.ROB_DEPTH(ROB_DEPTH)) i_dut (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_disp_valid(disp_valid), .i_disp_inst(disp_inst), .i_disp_pc(disp_pc),
    .o_disp_ready(disp_ready),
    .o_cmt_valid(cmt_valid), .o_cmt_illegal(cmt_illegal), .o_cmt_is_br(cmt_is_br),
    .o_cmt_rd(cmt_rd), .o_cmt_data(cmt_data),
    .o_cmt_br_taken(cmt_br_taken), .o_cmt_br_target(cmt_br_target)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Random source
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic branch_model(input br_cond_e cond, input data_t a, input data_t b);
    case (cond)
      EQ:      return a == b;
      NE:      return a != b;
      LT:      return $signed(a) < $signed(b);
      GE:      return $signed(a) >= $signed(b);
      LTU:     return a < b;
      GEU:     return a >= b;
      ALWAYS:  return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic mismatch_stop(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Failure at %0t: %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Roughly 60 % ALU, 30 % branch and 10 % reserved words over r0 to r7
  task automatic make_instruction(input int idx, output inst_word_u word, output pc_t pc);
    int          sel;
    logic [31:0] raw;
    word = '0;
    pc   = PC_BASE + 32'(idx * 4);
    sel  = int'(take_bits(16) % 100);
    if (sel < 60) begin
      word.alu.cat    = CAT_ALU;
      word.alu.op     = alu_op_e'(3'(take_bits(3)));
      word.alu.rd     = reg_idx_t'(take_bits(3));
      word.alu.rs1    = reg_idx_t'(take_bits(3));
      word.alu.rs2    = reg_idx_t'(take_bits(3));
      word.alu.imm_en = take_bits(1) != 0;
      word.alu.imm    = 14'(take_bits(14));
    end else if (sel < 90) begin
      word.bru.cat    = CAT_BRU;
      word.bru.cond   = br_cond_e'(3'(take_bits(3)));
      word.bru.rs1    = reg_idx_t'(take_bits(3));
      word.bru.rs2    = reg_idx_t'(take_bits(3));
      word.bru.offset = 19'(take_bits(19));
    end else begin
      raw  = take_bits(30);
      word = {(take_bits(1) != 0) ? 2'd3 : 2'd2, raw[29:0]};
    end
  endtask

  task automatic accept_instruction();
    cmt_exp_t want;
    data_t    a;
    data_t    b;
    want = '0;
    case (disp_inst.alu.cat)
      CAT_ALU: begin
        a = model_regs[disp_inst.alu.rs1];
        b = disp_inst.alu.imm_en ?
            data_t'($signed(disp_inst.alu.imm)) :
            model_regs[disp_inst.alu.rs2];
        want.rd   = disp_inst.alu.rd;
        want.data = alu_model(disp_inst.alu.op, a, b);
        model_regs[disp_inst.alu.rd] = want.data;
      end
      CAT_BRU: begin
        a = model_regs[disp_inst.bru.rs1];
        b = model_regs[disp_inst.bru.rs2];
        want.is_br  = 1'b1;
        want.taken  = branch_model(disp_inst.bru.cond, a, b);
        want.target = disp_pc + pc_t'($signed(disp_inst.bru.offset));
      end
      default: want.illegal = 1'b1;
    endcase
    exp_q.push_back(want);
    n_accepted++;
  endtask

  task automatic check_occupancy();
    assert (exp_q.size() <= ROB_DEPTH)
      else abort_run("more instructions in flight than the reorder buffer holds");
    if (exp_q.size() == ROB_DEPTH) begin
      assert (!disp_ready)
        else abort_run("dispatch ready while the reorder buffer is full");
    end
  endtask

  task automatic check_commit();
    cmt_exp_t want;
    assert (exp_q.size() != 0)
      else abort_run("commit strobe with no instruction in flight");
    want = exp_q.pop_front();
    assert (cmt_illegal == want.illegal)
      else mismatch_stop("o_cmt_illegal", 32'(cmt_illegal), 32'(want.illegal));
    assert (cmt_is_br == want.is_br)
      else mismatch_stop("o_cmt_is_br", 32'(cmt_is_br), 32'(want.is_br));
    if (want.illegal) begin
      n_ill_cmt++;
    end else if (want.is_br) begin
      assert (cmt_br_taken == want.taken)
        else mismatch_stop("o_cmt_br_taken", 32'(cmt_br_taken), 32'(want.taken));
      assert (cmt_br_target == want.target)
        else mismatch_stop("o_cmt_br_target", cmt_br_target, want.target);
      n_br_cmt++;
    end else begin
      assert (cmt_rd == want.rd)
        else mismatch_stop("o_cmt_rd", 32'(cmt_rd), 32'(want.rd));
      assert (cmt_data == want.data)
        else mismatch_stop("o_cmt_data", cmt_data, want.data);
      n_alu_cmt++;
    end
    n_committed++;
  endtask

  // --------------------
  // Monitor
  // --------------------
  // Falling edge sees the values that the next rising edge takes
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!cmt_valid) else abort_run("commit strobe raised during reset");
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions committed",
               cycle_count, n_committed, N_INSTR);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end else begin
      cycle_count++;
      check_occupancy();
      if (cmt_valid) begin
        check_commit();
      end
      if (disp_valid && disp_ready) begin
        accept_instruction();
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    inst_word_u word;
    pc_t        pc;
    rst_n       = 1'b0;
    disp_valid  = 1'b0;
    disp_inst   = '0;
    disp_pc     = '0;
    lfsr_state  = 32'h9d8a;
    n_accepted  = 0;
    n_committed = 0;
    cycle_count = 0;
    n_alu_cmt   = 0;
    n_br_cmt    = 0;
    n_ill_cmt   = 0;
    for (int r = 0; r < REG_NUM; r++) begin
      model_regs[r] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Word is held until taken while valid toggles randomly
    for (int idx = 0; idx < N_INSTR; idx++) begin
      make_instruction(idx, word, pc);
      disp_inst = word;
      disp_pc   = pc;
      do begin
        disp_valid = take_bits(2) != 0;
        @(posedge clk);
        #2;
      end while (n_accepted == idx);
    end
    disp_valid = 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);

    assert (n_alu_cmt > 0 && n_br_cmt > 0 && n_ill_cmt > 0)
      else abort_run("some instruction kind never committed");
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_tile_top
